/* gate_pkg.sv */
package gate_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Output rows and input vector length
  localparam int L_SIZE = 4;
  localparam int X_SIZE = 4;

  // Signed Q8.8 values
  localparam int DATA_W = 16;
  localparam int FRAC_W = 8;
  // Q16.16 products of L+X terms plus bias
  localparam int ACC_W  = 40;
  localparam int ADDR_W = 12;

  // Row and column index width, shared since L equals X
  localparam int IDX_W = $clog2(L_SIZE);

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  ////////////////////
  // Address map
  ////////////////////

  localparam logic [ADDR_W-1:0] ADDR_CTRL   = 12'h000;
  localparam logic [ADDR_W-1:0] ADDR_STATUS = 12'h004;
  localparam logic [ADDR_W-1:0] BASE_W      = 12'h040;
  localparam logic [ADDR_W-1:0] BASE_X      = 12'h080;
  localparam logic [ADDR_W-1:0] BASE_U      = 12'h0C0;
  localparam logic [ADDR_W-1:0] BASE_H      = 12'h100;
  localparam logic [ADDR_W-1:0] BASE_B      = 12'h140;
  localparam logic [ADDR_W-1:0] BASE_A      = 12'h180;

  // Lowest tag bit of a matrix and of a vector region
  localparam int MAT_LSB = $clog2(L_SIZE * X_SIZE) + 2;
  localparam int VEC_LSB = $clog2(L_SIZE) + 2;

  typedef enum logic [3:0] {
    REG_CTRL, REG_STATUS, REG_W, REG_X, REG_U, REG_H, REG_B, REG_A, REG_NONE
  } region_e;

  typedef enum logic [1:0] {EX_IDLE, EX_MAC, EX_BIAS, EX_PUSH} exec_state_e;

  ////////////////////
  // tanh approximation
  ////////////////////

  // Range after the Q8.8 shift, symmetric so the magnitude fits data_t
  localparam acc_t SAT_MAX = 40'sd32767;
  localparam acc_t SAT_MIN = -40'sd32767;

  // Knees at 0.5 and 2.0, second segment base 0.875, cap 1.0
  localparam data_t TANH_KNEE1 = 16'sd128;
  localparam data_t TANH_KNEE2 = 16'sd512;
  localparam data_t TANH_BASE2 = 16'sd224;
  localparam data_t ONE_Q      = 16'sd256;

endpackage

/* gate_operand_if.sv */
`timescale 1ns/1ps

interface gate_operand_if;

  // Operand position requested by execute
  logic [gate_pkg::IDX_W-1:0] row;
  logic [gate_pkg::IDX_W-1:0] col;
  // Low for the W*x pass, high for the U*h pass
  logic                       term;

  // Answered in the same cycle by the register file
  gate_pkg::data_t            coef;
  gate_pkg::data_t            vec;
  gate_pkg::data_t            bias;

  modport decode (
    input  row, col, term,
    output coef, vec, bias
  );

  modport execute (
    output row, col, term,
    input  coef, vec, bias
  );

endinterface

/* gate_sum_if.sv */
`timescale 1ns/1ps

interface gate_sum_if;

  // Row sum offered by execute
  logic                       valid;
  logic [gate_pkg::IDX_W-1:0] row;
  gate_pkg::acc_t             sum;
  // Result side can take a row
  logic                       ready;

  modport execute (
    output valid, row, sum,
    input  ready
  );

  modport result (
    input  valid, row, sum,
    output ready
  );

endinterface

/* gate_apb_decode.sv */
`timescale 1ns/1ps

module gate_apb_decode (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [gate_pkg::ADDR_W-1:0] paddr,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic                        start,
  input  logic                        done,
  output logic [gate_pkg::IDX_W-1:0]  a_index,
  input  gate_pkg::data_t             a_data,
  gate_operand_if.decode              op
);

  gate_pkg::region_e                   region;
  logic [gate_pkg::MAT_LSB-3:0]        mat_idx;
  logic [gate_pkg::VEC_LSB-3:0]        vec_idx;
  logic                                wr_acc;
  logic                                rd_acc;
  logic                                op_region;
  logic                                busy_q;
  logic                                done_q;

  // Operand register file, W and U row-major
  gate_pkg::data_t w_reg [gate_pkg::L_SIZE * gate_pkg::X_SIZE];
  gate_pkg::data_t u_reg [gate_pkg::L_SIZE * gate_pkg::L_SIZE];
  gate_pkg::data_t x_reg [gate_pkg::X_SIZE];
  gate_pkg::data_t h_reg [gate_pkg::L_SIZE];
  gate_pkg::data_t b_reg [gate_pkg::L_SIZE];

  // Address falls in the region whose tag starts at bit lsb
  function automatic logic hit(input logic [gate_pkg::ADDR_W-1:0] addr,
                               input logic [gate_pkg::ADDR_W-1:0] base,
                               input int lsb);
    return (addr >> lsb) == (base >> lsb);
  endfunction

  // Q8.8 value onto the 32-bit bus
  function automatic logic [31:0] sext(input gate_pkg::data_t v);
    return {{(32 - gate_pkg::DATA_W){v[gate_pkg::DATA_W-1]}}, v};
  endfunction

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    region = gate_pkg::REG_NONE;
    // Only word aligned accesses map anywhere
    if (paddr[1:0] == 2'b00) begin
      if (paddr == gate_pkg::ADDR_CTRL) begin
        region = gate_pkg::REG_CTRL;
      end else if (paddr == gate_pkg::ADDR_STATUS) begin
        region = gate_pkg::REG_STATUS;
      end else if (hit(paddr, gate_pkg::BASE_W, gate_pkg::MAT_LSB)) begin
        region = gate_pkg::REG_W;
      end else if (hit(paddr, gate_pkg::BASE_U, gate_pkg::MAT_LSB)) begin
        region = gate_pkg::REG_U;
      end else if (hit(paddr, gate_pkg::BASE_X, gate_pkg::VEC_LSB)) begin
        region = gate_pkg::REG_X;
      end else if (hit(paddr, gate_pkg::BASE_H, gate_pkg::VEC_LSB)) begin
        region = gate_pkg::REG_H;
      end else if (hit(paddr, gate_pkg::BASE_B, gate_pkg::VEC_LSB)) begin
        region = gate_pkg::REG_B;
      end else if (hit(paddr, gate_pkg::BASE_A, gate_pkg::VEC_LSB)) begin
        region = gate_pkg::REG_A;
      end
    end
  end

  assign mat_idx   = paddr[gate_pkg::MAT_LSB-1:2];
  assign vec_idx   = paddr[gate_pkg::VEC_LSB-1:2];
  assign a_index   = vec_idx;
  assign wr_acc    = psel & penable & pwrite;
  assign rd_acc    = psel & penable & ~pwrite;
  assign op_region = region inside {gate_pkg::REG_W, gate_pkg::REG_X, gate_pkg::REG_U,
                                    gate_pkg::REG_H, gate_pkg::REG_B};

  // No wait states
  assign pready = 1'b1;

  // Read-only, unmapped, or operand write while a run is active
  assign pslverr = wr_acc & ((region inside {gate_pkg::REG_STATUS, gate_pkg::REG_A,
                                             gate_pkg::REG_NONE}) | (op_region & busy_q));

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < gate_pkg::L_SIZE * gate_pkg::X_SIZE; i++) begin
        w_reg[i] <= '0;
      end
      for (int i = 0; i < gate_pkg::L_SIZE * gate_pkg::L_SIZE; i++) begin
        u_reg[i] <= '0;
      end
      for (int i = 0; i < gate_pkg::X_SIZE; i++) begin
        x_reg[i] <= '0;
      end
      for (int i = 0; i < gate_pkg::L_SIZE; i++) begin
        h_reg[i] <= '0;
        b_reg[i] <= '0;
      end
    end else if (wr_acc && op_region && !busy_q) begin
      case (region)
        gate_pkg::REG_W: w_reg[mat_idx] <= pwdata[gate_pkg::DATA_W-1:0];
        gate_pkg::REG_U: u_reg[mat_idx] <= pwdata[gate_pkg::DATA_W-1:0];
        gate_pkg::REG_X: x_reg[vec_idx] <= pwdata[gate_pkg::DATA_W-1:0];
        gate_pkg::REG_H: h_reg[vec_idx] <= pwdata[gate_pkg::DATA_W-1:0];
        gate_pkg::REG_B: b_reg[vec_idx] <= pwdata[gate_pkg::DATA_W-1:0];
        default: ;
      endcase
    end
  end

  // START launches a run, done pulse ends it
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      start  <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      start <= 1'b0;
      if (wr_acc && region == gate_pkg::REG_CTRL && pwdata[0] && !busy_q) begin
        start  <= 1'b1;
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (done) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // Read mux
  always_comb begin
    prdata = '0;
    if (rd_acc) begin
      case (region)
        gate_pkg::REG_STATUS: prdata = {30'd0, done_q, busy_q};
        gate_pkg::REG_W:      prdata = sext(w_reg[mat_idx]);
        gate_pkg::REG_U:      prdata = sext(u_reg[mat_idx]);
        gate_pkg::REG_X:      prdata = sext(x_reg[vec_idx]);
        gate_pkg::REG_H:      prdata = sext(h_reg[vec_idx]);
        gate_pkg::REG_B:      prdata = sext(b_reg[vec_idx]);
        gate_pkg::REG_A:      prdata = sext(a_data);
        default:              prdata = '0;
      endcase
    end
  end

  // Operand port for execute
  assign op.coef = op.term ? u_reg[op.row * gate_pkg::L_SIZE + op.col]
                           : w_reg[op.row * gate_pkg::X_SIZE + op.col];
  assign op.vec  = op.term ? h_reg[op.col] : x_reg[op.col];
  assign op.bias = b_reg[op.row];

  // A new run only launches from idle
  a_start_idle: assert property (@(posedge CLK) disable iff (RST)
    start |-> $past(!busy_q))
    else $error("start pulsed while busy");

endmodule

/* gate_mac_execute.sv */
`timescale 1ns/1ps

module gate_mac_execute (
  input  logic            CLK,
  input  logic            RST,
  input  logic            start,
  gate_operand_if.execute op,
  gate_sum_if.execute     sum
);

  gate_pkg::exec_state_e      state_q;
  logic [gate_pkg::IDX_W-1:0] row_q;
  logic [gate_pkg::IDX_W-1:0] col_q;
  logic                       term_q;
  logic                       col_last;
  int                         pass_len;
  gate_pkg::acc_t             acc_q;
  gate_pkg::acc_t             product;
  gate_pkg::acc_t             bias_ext;

  // W*x runs over X columns, U*h over L
  assign pass_len = term_q ? gate_pkg::L_SIZE : gate_pkg::X_SIZE;
  assign col_last = int'(col_q) == pass_len - 1;

  // Full Q16.16 product, no rounding
  assign product  = op.coef * op.vec;
  // Bias moved up to Q16.16
  assign bias_ext = gate_pkg::acc_t'(op.bias) <<< gate_pkg::FRAC_W;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= gate_pkg::EX_IDLE;
      row_q   <= '0;
      col_q   <= '0;
      term_q  <= 1'b0;
    end else begin
      case (state_q)
        gate_pkg::EX_IDLE: begin
          if (start) begin
            state_q <= gate_pkg::EX_MAC;
            row_q   <= '0;
            col_q   <= '0;
            term_q  <= 1'b0;
          end
        end
        gate_pkg::EX_MAC: begin
          if (col_last) begin
            col_q <= '0;
            // Second pass done, bias next
            if (term_q) begin
              state_q <= gate_pkg::EX_BIAS;
            end else begin
              term_q <= 1'b1;
            end
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        gate_pkg::EX_BIAS: begin
          state_q <= gate_pkg::EX_PUSH;
        end
        gate_pkg::EX_PUSH: begin
          // Hold the row until result takes it
          if (sum.ready) begin
            if (int'(row_q) == gate_pkg::L_SIZE - 1) begin
              state_q <= gate_pkg::EX_IDLE;
            end else begin
              row_q   <= row_q + 1'b1;
              term_q  <= 1'b0;
              state_q <= gate_pkg::EX_MAC;
            end
          end
        end
        default: state_q <= gate_pkg::EX_IDLE;
      endcase
    end
  end

  // Accumulator
  always_ff @(posedge CLK) begin
    case (state_q)
      gate_pkg::EX_IDLE: acc_q <= '0;
      gate_pkg::EX_MAC:  acc_q <= acc_q + product;
      gate_pkg::EX_BIAS: acc_q <= acc_q + bias_ext;
      gate_pkg::EX_PUSH: begin
        if (sum.ready) begin
          acc_q <= '0;
        end
      end
      default: ;
    endcase
  end

  assign op.row    = row_q;
  assign op.col    = col_q;
  assign op.term   = term_q;
  assign sum.valid = state_q == gate_pkg::EX_PUSH;
  assign sum.row   = row_q;
  assign sum.sum   = acc_q;

  // Offered row stays put until accepted
  a_sum_hold: assert property (@(posedge CLK) disable iff (RST)
    sum.valid && !sum.ready |=> sum.valid && $stable(sum.sum) && $stable(sum.row))
    else $error("row sum changed while stalled");

  a_col_range: assert property (@(posedge CLK) disable iff (RST)
    state_q == gate_pkg::EX_MAC |-> int'(col_q) < pass_len)
    else $error("column past pass length");

endmodule

/* gate_tanh_result.sv */
`timescale 1ns/1ps

module gate_tanh_result (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic [gate_pkg::IDX_W-1:0] a_index,
  gate_sum_if.result                 sum,
  output gate_pkg::data_t            a_data,
  output logic                       done
);

  gate_pkg::acc_t             shifted;
  gate_pkg::data_t            sat_val;
  logic                       accept;
  logic                       s1_valid;
  logic [gate_pkg::IDX_W-1:0] s1_row;
  gate_pkg::data_t            s1_val;
  gate_pkg::data_t            mag;
  gate_pkg::data_t            tanh_mag;
  gate_pkg::data_t            a_val;
  gate_pkg::data_t            a_buf [gate_pkg::L_SIZE];

  // Stage two drains stage one every cycle
  assign sum.ready = 1'b1;
  assign accept    = sum.valid & sum.ready;

  ////////////////////
  // Stage one
  ////////////////////

  // Q16.16 back to Q8.8
  assign shifted = sum.sum >>> gate_pkg::FRAC_W;

  always_comb begin
    if (shifted > gate_pkg::SAT_MAX) begin
      sat_val = gate_pkg::data_t'(gate_pkg::SAT_MAX);
    end else if (shifted < gate_pkg::SAT_MIN) begin
      sat_val = gate_pkg::data_t'(gate_pkg::SAT_MIN);
    end else begin
      sat_val = gate_pkg::data_t'(shifted);
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      s1_row <= sum.row;
      s1_val <= sat_val;
    end
  end

  ////////////////////
  // Stage two
  ////////////////////

  // Magnitude never overflows after symmetric saturation
  assign mag = s1_val[gate_pkg::DATA_W-1] ? -s1_val : s1_val;

  always_comb begin
    if (mag < gate_pkg::TANH_KNEE1) begin
      tanh_mag = mag;
    end else if (mag < gate_pkg::TANH_KNEE2) begin
      // Slope 1/4 from 0.5
      tanh_mag = gate_pkg::TANH_KNEE1 + ((mag - gate_pkg::TANH_KNEE1) >>> 2);
    end else begin
      // Slope 1/16 from 0.875
      tanh_mag = gate_pkg::TANH_BASE2 + ((mag - gate_pkg::TANH_KNEE2) >>> 4);
      if (tanh_mag > gate_pkg::ONE_Q) begin
        tanh_mag = gate_pkg::ONE_Q;
      end
    end
  end

  assign a_val = s1_val[gate_pkg::DATA_W-1] ? -tanh_mag : tanh_mag;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < gate_pkg::L_SIZE; i++) begin
        a_buf[i] <= '0;
      end
      s1_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      s1_valid <= accept;
      // Last row written ends the run
      done     <= s1_valid && int'(s1_row) == gate_pkg::L_SIZE - 1;
      if (s1_valid) begin
        a_buf[s1_row] <= a_val;
      end
    end
  end

  assign a_data = a_buf[a_index];

  // Stored activation within [-1.0, 1.0]
  a_out_bound: assert property (@(posedge CLK) disable iff (RST)
    s1_valid |=> a_buf[$past(s1_row)] <= gate_pkg::ONE_Q &&
                 a_buf[$past(s1_row)] >= -gate_pkg::ONE_Q)
    else $error("activation magnitude above one");

endmodule

/* activation_gate_vector.sv */
`timescale 1ns/1ps

module activation_gate_vector (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        PSEL,
  input  logic                        PENABLE,
  input  logic                        PWRITE,
  input  logic [gate_pkg::ADDR_W-1:0] PADDR,
  input  logic [31:0]                 PWDATA,
  output logic [31:0]                 PRDATA,
  output logic                        PREADY,
  output logic                        PSLVERR
);

  // Run control
  logic                       start;
  logic                       done;
  // A readback path
  logic [gate_pkg::IDX_W-1:0] a_index;
  gate_pkg::data_t            a_data;

  gate_operand_if op_if ();
  gate_sum_if     sum_if ();

  // APB slave and operand registers
  gate_apb_decode i_gate_apb_decode (
    .CLK     (CLK),
    .RST     (RST),
    .psel    (PSEL),
    .penable (PENABLE),
    .pwrite  (PWRITE),
    .paddr   (PADDR),
    .pwdata  (PWDATA),
    .prdata  (PRDATA),
    .pready  (PREADY),
    .pslverr (PSLVERR),
    .start   (start),
    .done    (done),
    .a_index (a_index),
    .a_data  (a_data),
    .op      (op_if.decode)
  );

  // Row sums
  gate_mac_execute i_gate_mac_execute (
    .CLK   (CLK),
    .RST   (RST),
    .start (start),
    .op    (op_if.execute),
    .sum   (sum_if.execute)
  );

  // tanh and A buffer
  gate_tanh_result i_gate_tanh_result (
    .CLK     (CLK),
    .RST     (RST),
    .a_index (a_index),
    .sum     (sum_if.result),
    .a_data  (a_data),
    .done    (done)
  );

endmodule

/* tb_gate_apb_tasks.svh */
////////////////////
// Reporting
////////////////////

// Ends the run when a wait loop gives up
task automatic timeout_fail(input string what);
  $display("Timeout: %s", what);
  $display("TEST FAILED");
  $fatal(1, "run stopped on timeout");
endtask

// Queue one comparison for the compare process
task automatic post_check(input string name, input int expected, input int actual);
  name_q.push_back(name);
  exp_q.push_back(expected);
  act_q.push_back(actual);
endtask

////////////////////
// APB master
////////////////////

// One transfer; inputs change on falling edges only
task automatic apb_transfer(input logic write, input logic [gate_pkg::ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
  int cycles;
  // Setup phase
  @(negedge CLK);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = write;
  paddr   = addr;
  pwdata  = wdata;
  // Access phase, sampled mid low phase before the completing edge
  @(negedge CLK);
  penable = 1'b1;
  cycles  = 0;
  #(HALF_PERIOD / 2);
  while (!pready) begin
    cycles++;
    if (cycles > APB_TIMEOUT) begin
      timeout_fail("PREADY never rose");
    end
    @(negedge CLK);
    #(HALF_PERIOD / 2);
  end
  rdata = prdata;
  err   = pslverr;
  @(negedge CLK);
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic write_reg(input logic [gate_pkg::ADDR_W-1:0] addr, input logic [31:0] data,
                         output logic err);
  logic [31:0] unused;
  apb_transfer(1'b1, addr, data, unused, err);
endtask

task automatic read_reg(input logic [gate_pkg::ADDR_W-1:0] addr, output logic [31:0] data);
  logic err;
  apb_transfer(1'b0, addr, 32'd0, data, err);
endtask

// Busy low and done high ends a run
task automatic poll_done();
  logic [31:0] st;
  int          polls;
  polls = 0;
  read_reg(gate_pkg::ADDR_STATUS, st);
  while (st[1:0] != 2'b10) begin
    polls++;
    if (polls > POLL_LIMIT) begin
      timeout_fail("STATUS never showed done");
    end
    read_reg(gate_pkg::ADDR_STATUS, st);
  end
endtask

////////////////////
// Reference model
////////////////////

// Pre-activation of one row in Q8.8, saturated to 16 bits
function automatic int row_sum(input int row);
  longint acc;
  longint v;
  acc = 0;
  for (int c = 0; c < X_SZ; c++) begin
    acc += longint'(w_m[row * X_SZ + c]) * longint'(x_v[c]);
  end
  for (int c = 0; c < L_SZ; c++) begin
    acc += longint'(u_m[row * L_SZ + c]) * longint'(h_v[c]);
  end
  // Bias up to Q16.16, then whole sum back to Q8.8
  acc += longint'(b_v[row]) * 256;
  v = acc >>> gate_pkg::FRAC_W;
  if (v > 32767) begin
    v = 32767;
  end else if (v < -32768) begin
    v = -32768;
  end
  return int'(v);
endfunction

// Piecewise tanh on the magnitude, sign put back last
function automatic int expected_gate(input int row);
  int v;
  int mag;
  int t;
  v   = row_sum(row);
  mag = (v < 0) ? -v : v;
  if (mag < 128) begin
    t = mag;
  end else if (mag < 512) begin
    t = 128 + (mag - 128) / 4;
  end else begin
    t = 224 + (mag - 512) / 16;
  end
  if (t > 256) begin
    t = 256;
  end
  return (v < 0) ? -t : t;
endfunction

/* tb_activation_gate_vector.sv */
`timescale 1ns/1ps

module tb_activation_gate_vector;

  localparam int HALF_PERIOD = 10;
  localparam int APB_TIMEOUT = 16;
  localparam int POLL_LIMIT  = 100;
  localparam int DRAIN_LIMIT = 20;
  localparam int L_SZ        = gate_pkg::L_SIZE;
  localparam int X_SZ        = gate_pkg::X_SIZE;
  // W, U, x, h, b flattened in that order
  localparam int N_OPS       = 2 * L_SZ * X_SZ + X_SZ + 2 * L_SZ;

  logic                        CLK;
  logic                        RST;
  logic                        psel;
  logic                        penable;
  logic                        pwrite;
  logic [gate_pkg::ADDR_W-1:0] paddr;
  logic [31:0]                 pwdata;
  logic [31:0]                 prdata;
  logic                        pready;
  logic                        pslverr;

  // Model copy of the loaded operands
  int w_m [L_SZ * X_SZ];
  int u_m [L_SZ * L_SZ];
  int x_v [X_SZ];
  int h_v [L_SZ];
  int b_v [L_SZ];

  // Pending comparisons
  string  name_q [$];
  int     exp_q [$];
  int     act_q [$];
  integer seed;

  `include "tb_gate_apb_tasks.svh"

  activation_gate_vector i_activation_gate_vector (
    .CLK     (CLK),
    .RST     (RST),
    .PSEL    (psel),
    .PENABLE (penable),
    .PWRITE  (pwrite),
    .PADDR   (paddr),
    .PWDATA  (pwdata),
    .PRDATA  (prdata),
    .PREADY  (pready),
    .PSLVERR (pslverr)
  );

  // 20 ns clock
  always #HALF_PERIOD CLK = ~CLK;

  ////////////////////
  // Operand access
  ////////////////////

  // Address and model value of flat operand k
  task automatic operand_word(input int k, output logic [gate_pkg::ADDR_W-1:0] addr,
                              output int value);
    if (k < 16) begin
      addr  = gate_pkg::BASE_W + 12'(4 * k);
      value = w_m[k];
    end else if (k < 32) begin
      addr  = gate_pkg::BASE_U + 12'(4 * (k - 16));
      value = u_m[k - 16];
    end else if (k < 36) begin
      addr  = gate_pkg::BASE_X + 12'(4 * (k - 32));
      value = x_v[k - 32];
    end else if (k < 40) begin
      addr  = gate_pkg::BASE_H + 12'(4 * (k - 36));
      value = h_v[k - 36];
    end else begin
      addr  = gate_pkg::BASE_B + 12'(4 * (k - 40));
      value = b_v[k - 40];
    end
  endtask

  // Write every operand, or read each one back when rd is high
  task automatic sweep_operands(input logic rd, input string name);
    logic [gate_pkg::ADDR_W-1:0] addr;
    logic [31:0]                 data;
    logic                        err;
    int                          value;
    for (int k = 0; k < N_OPS; k++) begin
      operand_word(k, addr, value);
      if (rd) begin
        read_reg(addr, data);
        post_check(name, value, int'(data));
      end else begin
        write_reg(addr, 32'(value), err);
        post_check(name, 0, int'(err));
      end
    end
  endtask

  // Range of each A word first, then its exact value
  task automatic check_gate(input string name);
    logic [31:0] data;
    int          a;
    for (int r = 0; r < L_SZ; r++) begin
      read_reg(gate_pkg::BASE_A + 12'(4 * r), data);
      a = int'(data);
      post_check({name, " bound"}, 1, int'(a <= 256 && a >= -256));
      post_check(name, expected_gate(r), a);
    end
  endtask

  ////////////////////
  // Compare process
  ////////////////////

  always @(posedge CLK) begin : compare
    string name;
    int    e;
    int    a;
    while (act_q.size() > 0) begin
      name = name_q.pop_front();
      e    = exp_q.pop_front();
      a    = act_q.pop_front();
      assert (a == e) else begin
        $display("Fail %s expected %0d actual %0d", name, e, a);
        $display("TEST FAILED");
        $fatal(1, "mismatch in %s", name);
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : run_tests
    logic [31:0] rd;
    logic        err;
    int          drain;
    CLK        = 1'b0;
    RST        = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    seed       = 32'h1d03e7c9;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Reset state and read-only A
    read_reg(gate_pkg::ADDR_STATUS, rd);
    post_check("reset status", 0, int'(rd));
    for (int r = 0; r < L_SZ; r++) begin
      read_reg(gate_pkg::BASE_A + 12'(4 * r), rd);
      post_check("reset A", 0, int'(rd));
    end
    write_reg(gate_pkg::BASE_A, 32'h100, err);
    post_check("write A error", 1, int'(err));

    // Linear region with every |sum| below 0.5
    for (int i = 0; i < L_SZ * X_SZ; i++) begin
      w_m[i] = (i % 7) * 16 - 48;
      u_m[i] = 40 - (i % 5) * 20;
    end
    x_v = '{64, -32, 16, 48};
    h_v = '{-64, 32, 24, -16};
    b_v = '{16, -12, 8, -16};
    sweep_operands(1'b0, "linear load error");
    sweep_operands(1'b1, "linear readback");
    write_reg(gate_pkg::ADDR_CTRL, 32'd1, err);
    poll_done();
    for (int r = 0; r < L_SZ; r++) begin
      read_reg(gate_pkg::BASE_A + 12'(4 * r), rd);
      post_check("linear A", row_sum(r), int'(rd));
    end

    // Both knees and saturation over two passes of opposite sign
    for (int s = 1; s >= -1; s -= 2) begin
      w_m = '{default: 0};
      u_m = '{default: 0};
      x_v = '{512, 0, -128, 0};
      h_v = '{-384, 0, 0, 0};
      w_m[0]  = 128 * s;
      w_m[4]  = -384 * s;
      w_m[8]  = 25600 * s;
      w_m[12] = -25600 * s;
      u_m[0]  = 64 * s;
      u_m[12] = 12800 * s;
      b_v     = '{64 * s, -32 * s, 0, 0};
      sweep_operands(1'b0, "large load error");
      write_reg(gate_pkg::ADDR_CTRL, 32'd1, err);
      poll_done();
      check_gate("large A");
    end

    // Random sets, done must clear at each START
    for (int n = 0; n < 20; n++) begin
      for (int i = 0; i < L_SZ * X_SZ; i++) begin
        w_m[i] = $random(seed) % 1024;
        u_m[i] = $random(seed) % 256;
      end
      for (int i = 0; i < L_SZ; i++) begin
        x_v[i] = $random(seed) % 1024;
        h_v[i] = $random(seed) % 256;
        b_v[i] = $random(seed) % 2048;
      end
      sweep_operands(1'b0, "random load error");
      write_reg(gate_pkg::ADDR_CTRL, 32'd1, err);
      read_reg(gate_pkg::ADDR_STATUS, rd);
      post_check("random status after start", 1, int'(rd));
      poll_done();
      check_gate("random A");
    end

    // Writes and START while busy leave the run alone
    write_reg(gate_pkg::ADDR_CTRL, 32'd1, err);
    write_reg(gate_pkg::BASE_W, 32'h7fff, err);
    post_check("busy W write error", 1, int'(err));
    write_reg(gate_pkg::BASE_B + 12'd4, 32'h0100, err);
    post_check("busy B write error", 1, int'(err));
    write_reg(gate_pkg::ADDR_CTRL, 32'd1, err);
    post_check("busy start error", 0, int'(err));
    read_reg(gate_pkg::ADDR_STATUS, rd);
    post_check("busy status", 1, int'(rd));
    poll_done();
    sweep_operands(1'b1, "busy readback");
    check_gate("busy A");

    // Let the compare process catch up
    drain = 0;
    while (act_q.size() > 0) begin
      drain++;
      if (drain > DRAIN_LIMIT) begin
        timeout_fail("compare queue never drained");
      end
      @(negedge CLK);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+.
gate_pkg.sv
gate_operand_if.sv
gate_sum_if.sv
gate_apb_decode.sv
gate_mac_execute.sv
gate_tanh_result.sv
activation_gate_vector.sv
tb_activation_gate_vector.sv
